// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  imem_addr_t;

    localparam int MEM_DEPTH = 64;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

endpackage

`default_nettype wire

// ==== if_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module if_stage
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_stall,
    input  wire logic                   i_flush,
    input  wire logic                   i_branch_taken,
    input  wire mips_pkg::word_t        i_branch_target,
    input  wire logic                   i_imem_we,
    input  wire mips_pkg::imem_addr_t   i_imem_addr,
    input  wire mips_pkg::word_t        i_imem_wdata,
    output mips_pkg::word_t             o_instr,
    output mips_pkg::word_t             o_pc4
);

    mips_pkg::word_t pc;
    mips_pkg::word_t pc4;
    mips_pkg::word_t imem [mips_pkg::MEM_DEPTH];

    assign pc4 = pc + 32'd4;

    // Loaded only while reset is held
    always_ff @(posedge i_clk)
    begin
        if (i_imem_we)
            imem[i_imem_addr] <= i_imem_wdata;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pc      <= '0;
            o_instr <= '0;
        end
        else
        begin
            if (i_branch_taken)
                pc <= i_branch_target;
            else if (!i_stall)
                pc <= pc4;

            // All-zero word decodes as a nop
            if (i_flush)
                o_instr <= '0;
            else if (!i_stall)
                o_instr <= imem[pc[7:2]];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
            o_pc4 <= pc4;
    end

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_unit
(
    input  wire logic [5:0]     i_opcode,
    input  wire logic [5:0]     i_funct,
    output logic                o_alu_src,
    output mips_pkg::alu_op_t   o_alu_op,
    output logic                o_reg_dst,
    output logic                o_branch,
    output logic                o_mem_write,
    output logic                o_mem_read,
    output logic                o_mem_to_reg,
    output logic                o_reg_write
);

    always_comb
    begin
        o_alu_src    = 1'b0;
        o_alu_op     = mips_pkg::ALU_ADD;
        o_reg_dst    = 1'b0;
        o_branch     = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_to_reg = 1'b0;
        o_reg_write  = 1'b0;

        case (i_opcode)
            mips_pkg::OP_RTYPE:
            begin
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
                case (i_funct)
                    mips_pkg::FUNCT_ADD: o_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FUNCT_SUB: o_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FUNCT_AND: o_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FUNCT_OR:  o_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FUNCT_SLT: o_alu_op = mips_pkg::ALU_SLT;
                    // Unknown funct, including the all-zero nop
                    default:
                    begin
                        o_reg_dst   = 1'b0;
                        o_reg_write = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_ADDI:
            begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
            end
            mips_pkg::OP_LW:
            begin
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
            end
            mips_pkg::OP_SW:
            begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ:
            begin
                o_branch = 1'b1;
                o_alu_op = mips_pkg::ALU_SUB;
            end
            default:
            begin
                o_branch = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire mips_pkg::reg_addr_t    i_rs,
    input  wire mips_pkg::reg_addr_t    i_rt,
    input  wire logic                   i_we,
    input  wire mips_pkg::reg_addr_t    i_wr_addr,
    input  wire mips_pkg::word_t        i_wr_data,
    output mips_pkg::word_t             o_rs_data,
    output mips_pkg::word_t             o_rt_data
);

    mips_pkg::word_t regs [32];

    // Bypass the write in progress so decode sees the writeback value
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (i_we && addr == i_wr_addr)
            return i_wr_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_wr_addr != '0)
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb
    begin
        o_rs_data = read_port(i_rs);
        o_rt_data = read_port(i_rt);
    end

endmodule

`default_nettype wire

// ==== id_ex_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_clear,
    input  wire mips_pkg::word_t        i_pc4,
    input  wire mips_pkg::word_t        i_rs_data,
    input  wire mips_pkg::word_t        i_rt_data,
    input  wire mips_pkg::word_t        i_imm,
    input  wire mips_pkg::reg_addr_t    i_rs,
    input  wire mips_pkg::reg_addr_t    i_rt,
    input  wire mips_pkg::reg_addr_t    i_rd,
    input  wire logic                   i_alu_src,
    input  wire mips_pkg::alu_op_t      i_alu_op,
    input  wire logic                   i_reg_dst,
    input  wire logic                   i_branch,
    input  wire logic                   i_mem_write,
    input  wire logic                   i_mem_read,
    input  wire logic                   i_mem_to_reg,
    input  wire logic                   i_reg_write,
    output mips_pkg::word_t             o_pc4,
    output mips_pkg::word_t             o_rs_data,
    output mips_pkg::word_t             o_rt_data,
    output mips_pkg::word_t             o_imm,
    output mips_pkg::reg_addr_t         o_rs,
    output mips_pkg::reg_addr_t         o_rt,
    output mips_pkg::reg_addr_t         o_rd,
    output logic                        o_alu_src,
    output mips_pkg::alu_op_t           o_alu_op,
    output logic                        o_reg_dst,
    output logic                        o_branch,
    output logic                        o_mem_write,
    output logic                        o_mem_read,
    output logic                        o_mem_to_reg,
    output logic                        o_reg_write
);

    always_ff @(posedge i_clk)
    begin
        o_pc4     <= i_pc4;
        o_rs_data <= i_rs_data;
        o_rt_data <= i_rt_data;
        o_imm     <= i_imm;
        o_rs      <= i_rs;
        o_rt      <= i_rt;
        o_rd      <= i_rd;
    end

    // Cleared control bits turn the slot into a bubble
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_clear)
        begin
            o_alu_src    <= 1'b0;
            o_alu_op     <= mips_pkg::ALU_ADD;
            o_reg_dst    <= 1'b0;
            o_branch     <= 1'b0;
            o_mem_write  <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_reg_write  <= 1'b0;
        end
        else
        begin
            o_alu_src    <= i_alu_src;
            o_alu_op     <= i_alu_op;
            o_reg_dst    <= i_reg_dst;
            o_branch     <= i_branch;
            o_mem_write  <= i_mem_write;
            o_mem_read   <= i_mem_read;
            o_mem_to_reg <= i_mem_to_reg;
            o_reg_write  <= i_reg_write;
        end
    end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_flush,
    input  wire mips_pkg::word_t        i_pc4,
    input  wire mips_pkg::word_t        i_rs_data,
    input  wire mips_pkg::word_t        i_rt_data,
    input  wire mips_pkg::word_t        i_imm,
    input  wire mips_pkg::reg_addr_t    i_rt,
    input  wire mips_pkg::reg_addr_t    i_rd,
    input  wire logic                   i_alu_src,
    input  wire mips_pkg::alu_op_t      i_alu_op,
    input  wire logic                   i_reg_dst,
    input  wire logic                   i_branch,
    input  wire logic                   i_mem_write,
    input  wire logic                   i_mem_read,
    input  wire logic                   i_mem_to_reg,
    input  wire logic                   i_reg_write,
    input  wire mips_pkg::fwd_sel_t     i_fwd_a,
    input  wire mips_pkg::fwd_sel_t     i_fwd_b,
    input  wire mips_pkg::word_t        i_wb_data,
    output mips_pkg::word_t             o_alu_result,
    output mips_pkg::word_t             o_store_data,
    output mips_pkg::word_t             o_branch_target,
    output logic                        o_zero,
    output mips_pkg::reg_addr_t         o_dest,
    output logic                        o_branch,
    output logic                        o_mem_write,
    output logic                        o_mem_read,
    output logic                        o_mem_to_reg,
    output logic                        o_reg_write
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t fwd_b;
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_y;

    function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_sel_t sel,
                                                input mips_pkg::word_t reg_val);
        case (sel)
            mips_pkg::FWD_MEM: return o_alu_result;
            mips_pkg::FWD_WB:  return i_wb_data;
            default:           return reg_val;
        endcase
    endfunction

    always_comb
    begin
        op_a  = fwd_mux(i_fwd_a, i_rs_data);
        fwd_b = fwd_mux(i_fwd_b, i_rt_data);
        op_b  = i_alu_src ? i_imm : fwd_b;
    end

    always_comb
    begin
        case (i_alu_op)
            mips_pkg::ALU_SUB: alu_y = op_a - op_b;
            mips_pkg::ALU_AND: alu_y = op_a & op_b;
            mips_pkg::ALU_OR:  alu_y = op_a | op_b;
            mips_pkg::ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           alu_y = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        o_alu_result    <= alu_y;
        o_zero          <= (alu_y == '0);
        o_store_data    <= fwd_b;
        o_branch_target <= i_pc4 + {i_imm[29:0], 2'b00};
        o_dest          <= i_reg_dst ? i_rd : i_rt;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_branch     <= 1'b0;
            o_mem_write  <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_reg_write  <= 1'b0;
        end
        else
        begin
            o_branch     <= i_branch;
            o_mem_write  <= i_mem_write;
            o_mem_read   <= i_mem_read;
            o_mem_to_reg <= i_mem_to_reg;
            o_reg_write  <= i_reg_write;
        end
    end

endmodule

`default_nettype wire

// ==== mem_wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire mips_pkg::word_t        i_alu_result,
    input  wire mips_pkg::word_t        i_store_data,
    input  wire mips_pkg::word_t        i_branch_target,
    input  wire logic                   i_zero,
    input  wire mips_pkg::reg_addr_t    i_dest,
    input  wire logic                   i_branch,
    input  wire logic                   i_mem_write,
    input  wire logic                   i_mem_read,
    input  wire logic                   i_mem_to_reg,
    input  wire logic                   i_reg_write,
    output logic                        o_branch_taken,
    output mips_pkg::word_t             o_branch_target,
    output logic                        o_wb_en,
    output mips_pkg::reg_addr_t         o_wb_dest,
    output mips_pkg::word_t             o_wb_data,
    output logic                        o_store_valid,
    output mips_pkg::imem_addr_t        o_store_addr,
    output mips_pkg::word_t             o_store_data
);

    mips_pkg::word_t      dmem [mips_pkg::MEM_DEPTH];
    mips_pkg::imem_addr_t addr;
    mips_pkg::word_t      load_q;
    mips_pkg::word_t      alu_q;
    logic                 mem_to_reg_q;

    assign addr            = i_alu_result[7:2];
    assign o_branch_taken  = i_branch && i_zero;
    assign o_branch_target = i_branch_target;

    always_ff @(posedge i_clk)
    begin
        if (i_mem_write)
            dmem[addr] <= i_store_data;
    end

    always_ff @(posedge i_clk)
    begin
        load_q       <= i_mem_read ? dmem[addr] : '0;
        alu_q        <= i_alu_result;
        o_wb_dest    <= i_dest;
        o_store_addr <= addr;
        o_store_data <= i_store_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_wb_en       <= 1'b0;
            o_store_valid <= 1'b0;
            mem_to_reg_q  <= 1'b0;
        end
        else
        begin
            // Register 0 never retires a write
            o_wb_en       <= i_reg_write && (i_dest != '0);
            o_store_valid <= i_mem_write;
            mem_to_reg_q  <= i_mem_to_reg;
        end
    end

    assign o_wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit
(
    input  wire mips_pkg::reg_addr_t    i_id_rs,
    input  wire mips_pkg::reg_addr_t    i_id_rt,
    input  wire mips_pkg::reg_addr_t    i_ex_rs,
    input  wire mips_pkg::reg_addr_t    i_ex_rt,
    input  wire mips_pkg::reg_addr_t    i_ex_rt_dest,
    input  wire logic                   i_ex_mem_read,
    input  wire mips_pkg::reg_addr_t    i_mem_dest,
    input  wire logic                   i_mem_reg_write,
    input  wire mips_pkg::reg_addr_t    i_wb_dest,
    input  wire logic                   i_wb_reg_write,
    input  wire logic                   i_branch_taken,
    output logic                        o_stall,
    output logic                        o_flush,
    output mips_pkg::fwd_sel_t          o_fwd_a,
    output mips_pkg::fwd_sel_t          o_fwd_b
);

    logic load_use;

    // Youngest producer wins
    function automatic mips_pkg::fwd_sel_t fwd_select(input mips_pkg::reg_addr_t src);
        if (i_mem_reg_write && i_mem_dest != '0 && i_mem_dest == src)
            return mips_pkg::FWD_MEM;
        else if (i_wb_reg_write && i_wb_dest != '0 && i_wb_dest == src)
            return mips_pkg::FWD_WB;
        else
            return mips_pkg::FWD_NONE;
    endfunction

    assign load_use = i_ex_mem_read && (i_ex_rt_dest != '0) &&
                      (i_ex_rt_dest == i_id_rs || i_ex_rt_dest == i_id_rt);

    assign o_flush = i_branch_taken;
    assign o_stall = load_use && !i_branch_taken;

    always_comb
    begin
        o_fwd_a = fwd_select(i_ex_rs);
        o_fwd_b = fwd_select(i_ex_rt);
    end

endmodule

`default_nettype wire

// ==== mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_imem_we,
    input  wire mips_pkg::imem_addr_t   i_imem_addr,
    input  wire mips_pkg::word_t        i_imem_wdata,
    output logic                        o_wb_valid,
    output mips_pkg::reg_addr_t         o_wb_reg,
    output mips_pkg::word_t             o_wb_data,
    output logic                        o_store_valid,
    output mips_pkg::imem_addr_t        o_store_addr,
    output mips_pkg::word_t             o_store_data
);

    mips_pkg::word_t      id_instr, id_pc4, id_rs_data, id_rt_data, id_imm;
    mips_pkg::alu_op_t    ctl_alu_op;
    logic                 ctl_alu_src, ctl_reg_dst, ctl_branch, ctl_mem_write;
    logic                 ctl_mem_read, ctl_mem_to_reg, ctl_reg_write;

    mips_pkg::word_t      ex_pc4, ex_rs_data, ex_rt_data, ex_imm;
    mips_pkg::reg_addr_t  ex_rs, ex_rt, ex_rd;
    mips_pkg::alu_op_t    ex_alu_op;
    logic                 ex_alu_src, ex_reg_dst, ex_branch, ex_mem_write;
    logic                 ex_mem_read, ex_mem_to_reg, ex_reg_write;

    mips_pkg::word_t      mem_alu_result, mem_store_data, mem_branch_target;
    mips_pkg::reg_addr_t  mem_dest;
    logic                 mem_zero, mem_branch, mem_mem_write, mem_mem_read;
    logic                 mem_mem_to_reg, mem_reg_write;

    mips_pkg::word_t      br_target;
    logic                 br_taken, stall, flush;
    mips_pkg::fwd_sel_t   fwd_a, fwd_b;

    assign id_imm = {{16{id_instr[15]}}, id_instr[15:0]};

    if_stage u_if (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(stall), .i_flush(flush),
        .i_branch_taken(br_taken), .i_branch_target(br_target),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_wdata(i_imem_wdata),
        .o_instr(id_instr), .o_pc4(id_pc4)
    );

    control_unit u_ctl (
        .i_opcode(id_instr[31:26]), .i_funct(id_instr[5:0]),
        .o_alu_src(ctl_alu_src), .o_alu_op(ctl_alu_op), .o_reg_dst(ctl_reg_dst),
        .o_branch(ctl_branch), .o_mem_write(ctl_mem_write), .o_mem_read(ctl_mem_read),
        .o_mem_to_reg(ctl_mem_to_reg), .o_reg_write(ctl_reg_write)
    );

    register_file u_rf (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rs(id_instr[25:21]), .i_rt(id_instr[20:16]),
        .i_we(o_wb_valid), .i_wr_addr(o_wb_reg), .i_wr_data(o_wb_data),
        .o_rs_data(id_rs_data), .o_rt_data(id_rt_data)
    );

    id_ex_reg u_id_ex (
        .i_clk(i_clk), .i_reset(i_reset), .i_clear(stall | flush),
        .i_pc4(id_pc4), .i_rs_data(id_rs_data), .i_rt_data(id_rt_data), .i_imm(id_imm),
        .i_rs(id_instr[25:21]), .i_rt(id_instr[20:16]), .i_rd(id_instr[15:11]),
        .i_alu_src(ctl_alu_src), .i_alu_op(ctl_alu_op), .i_reg_dst(ctl_reg_dst),
        .i_branch(ctl_branch), .i_mem_write(ctl_mem_write), .i_mem_read(ctl_mem_read),
        .i_mem_to_reg(ctl_mem_to_reg), .i_reg_write(ctl_reg_write),
        .o_pc4(ex_pc4), .o_rs_data(ex_rs_data), .o_rt_data(ex_rt_data), .o_imm(ex_imm),
        .o_rs(ex_rs), .o_rt(ex_rt), .o_rd(ex_rd),
        .o_alu_src(ex_alu_src), .o_alu_op(ex_alu_op), .o_reg_dst(ex_reg_dst),
        .o_branch(ex_branch), .o_mem_write(ex_mem_write), .o_mem_read(ex_mem_read),
        .o_mem_to_reg(ex_mem_to_reg), .o_reg_write(ex_reg_write)
    );

    ex_stage u_ex (
        .i_clk(i_clk), .i_reset(i_reset), .i_flush(flush),
        .i_pc4(ex_pc4), .i_rs_data(ex_rs_data), .i_rt_data(ex_rt_data), .i_imm(ex_imm),
        .i_rt(ex_rt), .i_rd(ex_rd),
        .i_alu_src(ex_alu_src), .i_alu_op(ex_alu_op), .i_reg_dst(ex_reg_dst),
        .i_branch(ex_branch), .i_mem_write(ex_mem_write), .i_mem_read(ex_mem_read),
        .i_mem_to_reg(ex_mem_to_reg), .i_reg_write(ex_reg_write),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_wb_data(o_wb_data),
        .o_alu_result(mem_alu_result), .o_store_data(mem_store_data),
        .o_branch_target(mem_branch_target), .o_zero(mem_zero), .o_dest(mem_dest),
        .o_branch(mem_branch), .o_mem_write(mem_mem_write), .o_mem_read(mem_mem_read),
        .o_mem_to_reg(mem_mem_to_reg), .o_reg_write(mem_reg_write)
    );

    mem_wb_stage u_mem_wb (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_alu_result(mem_alu_result), .i_store_data(mem_store_data),
        .i_branch_target(mem_branch_target), .i_zero(mem_zero), .i_dest(mem_dest),
        .i_branch(mem_branch), .i_mem_write(mem_mem_write), .i_mem_read(mem_mem_read),
        .i_mem_to_reg(mem_mem_to_reg), .i_reg_write(mem_reg_write),
        .o_branch_taken(br_taken), .o_branch_target(br_target),
        .o_wb_en(o_wb_valid), .o_wb_dest(o_wb_reg), .o_wb_data(o_wb_data),
        .o_store_valid(o_store_valid), .o_store_addr(o_store_addr),
        .o_store_data(o_store_data)
    );

    hazard_unit u_hazard (
        .i_id_rs(id_instr[25:21]), .i_id_rt(id_instr[20:16]),
        .i_ex_rs(ex_rs), .i_ex_rt(ex_rt), .i_ex_rt_dest(ex_rt),
        .i_ex_mem_read(ex_mem_read),
        .i_mem_dest(mem_dest), .i_mem_reg_write(mem_reg_write),
        .i_wb_dest(o_wb_reg), .i_wb_reg_write(o_wb_valid),
        .i_branch_taken(br_taken),
        .o_stall(stall), .o_flush(flush), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

// ==== mips_core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core_checker
(
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_flush,
    input  wire mips_pkg::word_t        i_id_instr,
    input  wire logic                   i_wb_valid,
    input  wire mips_pkg::reg_addr_t    i_wb_reg,
    input  wire logic                   i_store_valid
);

    // Flush must win over a load-use stall, so IF/ID always becomes a nop
    assert property (@(posedge i_clk) disable iff (i_reset) i_flush |=> i_id_instr == '0)
        else $error("IF/ID held instead of cleared after a flush");

    assert property (@(posedge i_clk) disable iff (i_reset) i_wb_valid |-> i_wb_reg != '0)
        else $error("writeback reported for register 0");

    assert property (@(posedge i_clk) i_reset |=> !i_store_valid)
        else $error("store valid right after reset");

endmodule

bind mips_core mips_core_checker u_checker (
    .i_clk(i_clk), .i_reset(i_reset), .i_flush(flush), .i_id_instr(id_instr),
    .i_wb_valid(o_wb_valid), .i_wb_reg(o_wb_reg), .i_store_valid(o_store_valid)
);

`default_nettype wire

// ==== tb_mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

    localparam int PROG_LEN       = 35;
    localparam int DRAIN_CYCLES   = 20;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 100;

    logic                 clk;
    logic                 reset;
    logic                 imem_we;
    mips_pkg::imem_addr_t imem_addr;
    mips_pkg::word_t      imem_wdata;
    logic                 wb_valid;
    mips_pkg::reg_addr_t  wb_reg;
    mips_pkg::word_t      wb_data;
    logic                 store_valid;
    mips_pkg::imem_addr_t store_addr;
    mips_pkg::word_t      store_data;

    mips_pkg::word_t program_words [PROG_LEN];
    logic [63:0]     expected_q [$];
    logic [31:0]     lfsr_state;

    mips_core u_dut (
        .i_clk(clk), .i_reset(reset),
        .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_wdata(imem_wdata),
        .o_wb_valid(wb_valid), .o_wb_reg(wb_reg), .o_wb_data(wb_data),
        .o_store_valid(store_valid), .o_store_addr(store_addr), .o_store_data(store_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per immediate bit
    function automatic logic [15:0] random_imm();
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < 16; i++)
        begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic mips_pkg::word_t r_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_pkg::word_t i_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [63:0] pack_event(input logic is_store, input logic [5:0] index,
                                               input mips_pkg::word_t data);
        return {25'd0, is_store, index, data};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
            fail_run($sformatf("Error at %0t ns: %s got %h expected %h",
                               $time, what, actual, expected));
    endtask

    task automatic build_program();
        lfsr_state = 32'h45006355;
        program_words[0]  = i_word(mips_pkg::OP_ADDI, 5'd1, 5'd0, random_imm());
        program_words[1]  = i_word(mips_pkg::OP_ADDI, 5'd2, 5'd0, random_imm());
        program_words[2]  = i_word(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'hFFFB);
        // Forwarding chain through EX/MEM and MEM/WB
        program_words[3]  = r_word(mips_pkg::FUNCT_ADD, 5'd4, 5'd1, 5'd2);
        program_words[4]  = r_word(mips_pkg::FUNCT_SUB, 5'd5, 5'd4, 5'd3);
        program_words[5]  = r_word(mips_pkg::FUNCT_AND, 5'd6, 5'd4, 5'd5);
        program_words[6]  = r_word(mips_pkg::FUNCT_OR, 5'd7, 5'd6, 5'd1);
        program_words[7]  = r_word(mips_pkg::FUNCT_SLT, 5'd8, 5'd3, 5'd1);
        program_words[8]  = r_word(mips_pkg::FUNCT_SLT, 5'd9, 5'd1, 5'd3);
        program_words[9]  = i_word(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'd7);
        program_words[10] = r_word(mips_pkg::FUNCT_ADD, 5'd0, 5'd1, 5'd2);
        program_words[11] = r_word(mips_pkg::FUNCT_ADD, 5'd10, 5'd0, 5'd9);
        // Store, reload and immediate use
        program_words[12] = i_word(mips_pkg::OP_ADDI, 5'd11, 5'd0, 16'd16);
        program_words[13] = i_word(mips_pkg::OP_SW, 5'd7, 5'd11, 16'd0);
        program_words[14] = i_word(mips_pkg::OP_LW, 5'd12, 5'd11, 16'd0);
        program_words[15] = r_word(mips_pkg::FUNCT_ADD, 5'd13, 5'd12, 5'd1);
        program_words[16] = i_word(mips_pkg::OP_SW, 5'd13, 5'd11, 16'd4);
        program_words[17] = i_word(mips_pkg::OP_LW, 5'd14, 5'd11, 16'd4);
        program_words[18] = r_word(mips_pkg::FUNCT_SUB, 5'd15, 5'd14, 5'd12);
        // Taken branch over three instructions, a load-use pair among them
        program_words[19] = i_word(mips_pkg::OP_BEQ, 5'd1, 5'd1, 16'd3);
        program_words[20] = i_word(mips_pkg::OP_LW, 5'd16, 5'd11, 16'd0);
        program_words[21] = r_word(mips_pkg::FUNCT_ADD, 5'd17, 5'd16, 5'd1);
        program_words[22] = i_word(mips_pkg::OP_SW, 5'd1, 5'd11, 16'd8);
        program_words[23] = i_word(mips_pkg::OP_ADDI, 5'd18, 5'd0, random_imm());
        program_words[24] = i_word(mips_pkg::OP_BEQ, 5'd11, 5'd0, 16'd5);
        program_words[25] = i_word(mips_pkg::OP_ADDI, 5'd19, 5'd0, 16'd3);
        program_words[26] = r_word(mips_pkg::FUNCT_OR, 5'd20, 5'd19, 5'd18);
        program_words[27] = i_word(mips_pkg::OP_SW, 5'd20, 5'd11, 16'd12);
        program_words[28] = r_word(mips_pkg::FUNCT_SLT, 5'd21, 5'd18, 5'd2);
        program_words[29] = i_word(mips_pkg::OP_ADDI, 5'd22, 5'd0, 16'd3);
        program_words[30] = i_word(mips_pkg::OP_BEQ, 5'd19, 5'd22, 16'd2);
        program_words[31] = i_word(mips_pkg::OP_ADDI, 5'd23, 5'd0, 16'd9);
        program_words[32] = i_word(mips_pkg::OP_ADDI, 5'd24, 5'd0, 16'd9);
        program_words[33] = r_word(mips_pkg::FUNCT_ADD, 5'd25, 5'd22, 5'd19);
        program_words[34] = i_word(mips_pkg::OP_SW, 5'd25, 5'd11, 16'd16);
    endtask

    // Architectural model, one instruction per step in program order
    task automatic run_golden_model();
        mips_pkg::word_t     regs [32];
        mips_pkg::word_t     dmem [int];
        mips_pkg::word_t     instr;
        mips_pkg::word_t     imm;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     res;
        mips_pkg::reg_addr_t dest;
        logic                writes;
        int                  pc;
        pc = 0;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        while (pc < PROG_LEN)
        begin
            instr  = program_words[pc];
            imm    = {{16{instr[15]}}, instr[15:0]};
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            dest   = instr[20:16];
            writes = 1'b0;
            res    = '0;
            pc     = pc + 1;
            case (instr[31:26])
                mips_pkg::OP_RTYPE:
                begin
                    dest   = instr[15:11];
                    writes = 1'b1;
                    case (instr[5:0])
                        mips_pkg::FUNCT_ADD: res = a + b;
                        mips_pkg::FUNCT_SUB: res = a - b;
                        mips_pkg::FUNCT_AND: res = a & b;
                        mips_pkg::FUNCT_OR:  res = a | b;
                        mips_pkg::FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:             writes = 1'b0;
                    endcase
                end
                mips_pkg::OP_ADDI:
                begin
                    res    = a + imm;
                    writes = 1'b1;
                end
                mips_pkg::OP_LW:
                begin
                    res    = a + imm;
                    res    = dmem[int'(res[7:2])];
                    writes = 1'b1;
                end
                mips_pkg::OP_SW:
                begin
                    res = a + imm;
                    dmem[int'(res[7:2])] = b;
                    expected_q.push_back(pack_event(1'b1, res[7:2], b));
                end
                mips_pkg::OP_BEQ:
                begin
                    if (a == b)
                        pc = pc + $signed(imm);
                end
                default:
                begin
                    writes = 1'b0;
                end
            endcase
            if (writes && dest != '0)
            begin
                regs[dest] = res;
                expected_q.push_back(pack_event(1'b0, {1'b0, dest}, res));
            end
        end
    endtask

    task automatic compare_event(input logic [63:0] actual);
        if (expected_q.size() == 0)
            fail_run("DUT reported a register write or store that the program never makes");
        else
        begin
            check_equal("event {store, index, data}", actual, expected_q.pop_front());
        end
    endtask

    always @(negedge clk)
    begin
        if (reset)
            check_equal("event valid during reset", {62'd0, wb_valid, store_valid}, 64'd0);
        else
        begin
            if (wb_valid)
                compare_event(pack_event(1'b0, {1'b0, wb_reg}, wb_data));
            if (store_valid)
                compare_event(pack_event(1'b1, store_addr, store_data));
        end
    end

    initial
    begin
        @(negedge reset);
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run("Watchdog timeout: the core did not retire every expected event in time");
    end

    initial
    begin
        reset       = 1'b1;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        build_program();
        run_golden_model();

        // Filler past the program is an R-type word with an unused funct, so it decodes as a nop
        for (int i = 0; i < mips_pkg::MEM_DEPTH; i++)
        begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = mips_pkg::imem_addr_t'(i);
            if (i < PROG_LEN)
                imem_wdata = program_words[i];
            else
                imem_wdata = {mips_pkg::OP_RTYPE, 20'(i), 6'h3f};
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        while (expected_q.size() != 0)
            @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
mips_pkg.sv
if_stage.sv
control_unit.sv
register_file.sv
id_ex_reg.sv
ex_stage.sv
mem_wb_stage.sv
hazard_unit.sv
mips_core.sv
mips_core_checker.sv
tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - if_stage.sv
  - control_unit.sv
  - register_file.sv
  - id_ex_reg.sv
  - ex_stage.sv
  - mem_wb_stage.sv
  - hazard_unit.sv
  - mips_core.sv
  - target: simulation
    files:
      - mips_core_checker.sv
      - tb_mips_core.sv
